// File: Bender.yml
package:
  name: stepper_ctrl

sources:
  - stepper_ctrl_pkg.sv
  - move_if.sv
  - spi_word_rx.sv
  - cmd_decoder.sv
  - dda_step_gen.sv
  - hbridge_phase.sv
  - quad_counter.sv
  - stepper_ctrl_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_stepper_ctrl.sv

// File: cmd_decoder.sv
`timescale 1ns/1ns

module cmd_decoder #(
  parameter int MOVE_DEPTH = 4
) (
  input  logic                                        CLK,
  input  logic                                        reset,
  input  logic                                        word_strobe,
  input  logic [stepper_ctrl_pkg::word_bits-1:0]        word_data,
  input  logic signed [stepper_ctrl_pkg::word_bits-1:0] enc_count,
  output logic [stepper_ctrl_pkg::word_bits-1:0]        reply_data,
  output logic [23:0]                                 clock_divisor,
  output logic                                        half_step,
  move_if.producer                                    mv
);
  import stepper_ctrl_pkg::*;

  localparam int ptr_bits = $clog2(MOVE_DEPTH);

  // Message position
  localparam logic [2:0] st_header    = 3'd0;
  localparam logic [2:0] st_duration  = 3'd1;
  localparam logic [2:0] st_increment = 3'd2;
  localparam logic [2:0] st_incr_incr = 3'd3;
  localparam logic [2:0] st_skip      = 3'd4;

  cmd_word_u                   cmd_word;
  logic [2:0]                  msg_state;
  logic                        push;
  logic                        full;
  logic [ptr_bits:0]           wr_ptr;
  logic [ptr_bits:0]           rd_ptr;
  // Move being assembled
  logic                        stage_dir;
  logic [word_bits-1:0]        stage_duration;
  logic signed [word_bits-1:0] stage_increment;
  // Move queue storage
  logic                        q_dir       [MOVE_DEPTH];
  logic [word_bits-1:0]        q_duration  [MOVE_DEPTH];
  logic signed [word_bits-1:0] q_increment [MOVE_DEPTH];
  logic signed [word_bits-1:0] q_incr_incr [MOVE_DEPTH];

  assign cmd_word = word_data;

  // Third data word completes the move
  assign push = word_strobe && (msg_state == st_incr_incr);
  // Pointers carry one wrap bit
  assign full = (wr_ptr[ptr_bits] != rd_ptr[ptr_bits]) &&
                (wr_ptr[ptr_bits-1:0] == rd_ptr[ptr_bits-1:0]);

  assign mv.avail     = (wr_ptr != rd_ptr);
  assign mv.dir       = q_dir[rd_ptr[ptr_bits-1:0]];
  assign mv.duration  = q_duration[rd_ptr[ptr_bits-1:0]];
  assign mv.increment = q_increment[rd_ptr[ptr_bits-1:0]];
  assign mv.incr_incr = q_incr_incr[rd_ptr[ptr_bits-1:0]];

  always_ff @(posedge CLK) begin
    if (reset) begin
      msg_state     <= st_header;
      clock_divisor <= default_divisor;
      half_step     <= 1'b0;
      reply_data    <= '0;
    end else if (word_strobe) begin
      // Default reply is the encoder count at this word
      reply_data <= enc_count;
      case (msg_state)
        st_header: begin
          case (cmd_word.hdr.header)
            cmd_move:      msg_state <= st_duration;
            cmd_divisor:   clock_divisor <= cmd_word.hdr.payload[23:0];
            cmd_step_mode: half_step <= cmd_word.hdr.payload[0];
            cmd_version: begin
              reply_data <= {{(word_bits-24){1'b0}}, version_major, version_minor,
                             version_patch};
              msg_state  <= st_skip;
            end
            default: ;
          endcase
        end
        st_duration:  msg_state <= st_increment;
        st_increment: msg_state <= st_incr_incr;
        // Incr_incr word, or the word after a version header
        default:      msg_state <= st_header;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (mv.pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (word_strobe && msg_state == st_header && cmd_word.hdr.header == cmd_move) begin
      // Direction rides in the header word
      stage_dir <= cmd_word.hdr.payload[0];
    end
    if (word_strobe && msg_state == st_duration) begin
      stage_duration <= cmd_word.data;
    end
    if (word_strobe && msg_state == st_increment) begin
      stage_increment <= cmd_word.data;
    end
    if (push) begin
      q_dir[wr_ptr[ptr_bits-1:0]]       <= stage_dir;
      q_duration[wr_ptr[ptr_bits-1:0]]  <= stage_duration;
      q_increment[wr_ptr[ptr_bits-1:0]] <= stage_increment;
      q_incr_incr[wr_ptr[ptr_bits-1:0]] <= cmd_word.data;
    end
  end

  // Host must not overrun the queue
  a_no_push_full : assert property (@(posedge CLK) disable iff (reset) push |-> !full);
  // Step generator only pops a queued move
  a_no_pop_empty : assert property (@(posedge CLK) disable iff (reset) mv.pop |-> mv.avail);

endmodule

// File: dda_step_gen.sv
`timescale 1ns/1ns

module dda_step_gen (
  input  logic        CLK,
  input  logic        reset,
  input  logic [23:0] clock_divisor,
  move_if.consumer    mv,
  output logic        step,
  output logic        dir
);
  import stepper_ctrl_pkg::*;

  logic                        busy;
  logic                        first_tick;
  logic                        tick;
  logic [23:0]                 div_cnt;
  logic [word_bits-1:0]        ticks_left;
  logic signed [word_bits-1:0] incr_r;
  logic signed [word_bits-1:0] cur_incr_incr;
  logic signed [word_bits-1:0] accum;
  logic signed [word_bits-1:0] incr_next;
  logic signed [word_bits-1:0] accum_sum;

  assign tick = busy && (div_cnt == clock_divisor - 24'd1);

  // Initial increment on the first tick, then ramp
  assign incr_next = first_tick ? incr_r : incr_r + cur_incr_incr;
  assign accum_sum = accum + incr_next;

  always_ff @(posedge CLK) begin
    if (reset) begin
      busy       <= 1'b0;
      first_tick <= 1'b0;
      mv.pop     <= 1'b0;
      step       <= 1'b0;
      dir        <= 1'b0;
      div_cnt    <= '0;
      ticks_left <= '0;
      accum      <= '0;
    end else begin
      mv.pop <= 1'b0;
      step   <= 1'b0;
      // Latch the head while pop is high
      if (mv.pop) begin
        busy       <= (mv.duration != '0);
        first_tick <= 1'b1;
        dir        <= mv.dir;
        ticks_left <= mv.duration;
        div_cnt    <= '0;
      end else if (!busy && mv.avail) begin
        mv.pop <= 1'b1;
      end
      if (busy) begin
        if (tick) begin
          div_cnt    <= '0;
          first_tick <= 1'b0;
          ticks_left <= ticks_left - 1'b1;
          // Last tick of this move
          if (ticks_left == 1) begin
            busy <= 1'b0;
          end
          // Accumulator carries over between moves
          if (accum_sum > 0) begin
            step  <= 1'b1;
            accum <= accum_sum - dda_threshold;
          end else begin
            accum <= accum_sum;
          end
        end else begin
          div_cnt <= div_cnt + 24'd1;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (mv.pop) begin
      incr_r        <= mv.increment;
      cur_incr_incr <= mv.incr_incr;
    end else if (tick) begin
      incr_r <= incr_next;
    end
  end

  a_step_one_cycle : assert property (@(posedge CLK) disable iff (reset) step |=> !step);

endmodule

// File: hbridge_phase.sv
`timescale 1ns/1ns

module hbridge_phase (
  input  logic CLK,
  input  logic reset,
  input  logic step,
  input  logic dir,
  input  logic half_step,
  output logic phase_a1,
  output logic phase_a2,
  output logic phase_b1,
  output logic phase_b2
);

  logic [2:0] idx;
  logic [2:0] delta;

  // Full step skips the single-coil states
  assign delta = half_step ? 3'd1 : 3'd2;

  always_ff @(posedge CLK) begin
    if (reset) begin
      idx <= 3'd0;
    end else if (step) begin
      idx <= dir ? idx + delta : idx - delta;
    end
  end

  // Eight-state half-step table, {a1, a2, b1, b2}
  always_comb begin
    case (idx)
      3'd0:    {phase_a1, phase_a2, phase_b1, phase_b2} = 4'b1010;
      3'd1:    {phase_a1, phase_a2, phase_b1, phase_b2} = 4'b0010;
      3'd2:    {phase_a1, phase_a2, phase_b1, phase_b2} = 4'b0110;
      3'd3:    {phase_a1, phase_a2, phase_b1, phase_b2} = 4'b0100;
      3'd4:    {phase_a1, phase_a2, phase_b1, phase_b2} = 4'b0101;
      3'd5:    {phase_a1, phase_a2, phase_b1, phase_b2} = 4'b0001;
      3'd6:    {phase_a1, phase_a2, phase_b1, phase_b2} = 4'b1001;
      default: {phase_a1, phase_a2, phase_b1, phase_b2} = 4'b1000;
    endcase
  end

endmodule

// File: move_if.sv
`timescale 1ns/1ns

interface move_if;
  import stepper_ctrl_pkg::*;

  // Queue non-empty
  logic                        avail;
  // Removes the head, one cycle
  logic                        pop;
  // Head of the queue
  logic                        dir;
  logic [word_bits-1:0]        duration;
  logic signed [word_bits-1:0] increment;
  logic signed [word_bits-1:0] incr_incr;

  modport producer (output avail, dir, duration, increment, incr_incr, input pop);
  modport consumer (input avail, dir, duration, increment, incr_incr, output pop);

endinterface

// File: quad_counter.sv
`timescale 1ns/1ns

module quad_counter (
  input  logic               CLK,
  input  logic               reset,
  input  logic               enc_a,
  input  logic               enc_b,
  output logic signed [63:0] count,
  output logic               fault
);

  logic [1:0] a_r;
  logic [1:0] b_r;
  // Previous synchronized {A, B}
  logic [1:0] prev_ab;
  logic [1:0] cur_ab;
  logic [1:0] changed;
  logic       count_up;

  assign cur_ab  = {a_r[1], b_r[1]};
  assign changed = cur_ab ^ prev_ab;
  // A leading B, new A differs from old B
  assign count_up = cur_ab[1] ^ prev_ab[0];

  always_ff @(posedge CLK) begin
    if (reset) begin
      a_r     <= '0;
      b_r     <= '0;
      prev_ab <= '0;
      count   <= '0;
      fault   <= 1'b0;
    end else begin
      a_r     <= {a_r[0], enc_a};
      b_r     <= {b_r[0], enc_b};
      prev_ab <= cur_ab;
      if (changed == 2'b01 || changed == 2'b10) begin
        count <= count_up ? count + 64'sd1 : count - 64'sd1;
      end
      // Both edges at once, position lost, sticky
      if (changed == 2'b11) begin
        fault <= 1'b1;
      end
    end
  end

endmodule

// File: spi_word_rx.sv
`timescale 1ns/1ns

module spi_word_rx (
  input  logic                                 CLK,
  input  logic                                 reset,
  input  logic                                 sck,
  input  logic                                 cs_n,
  input  logic                                 copi,
  output logic                                 cipo,
  output logic                                 word_strobe,
  output logic [stepper_ctrl_pkg::word_bits-1:0] word_data,
  input  logic [stepper_ctrl_pkg::word_bits-1:0] reply_data
);
  import stepper_ctrl_pkg::*;

  // Two sync stages plus history for edge detection
  logic [2:0]           sck_r;
  logic [3:0]           cs_r;
  logic [1:0]           copi_r;
  logic                 in_frame;
  logic                 sck_rise;
  logic                 sck_fall;
  logic                 frame_start;
  logic                 frame_end;
  logic [word_bits-1:0] rx_shift;
  logic [word_bits-1:0] tx_shift;

  assign in_frame    = ~cs_r[1];
  assign sck_rise    = sck_r[1] & ~sck_r[2];
  assign sck_fall    = ~sck_r[1] & sck_r[2];
  assign frame_start = ~cs_r[1] & cs_r[2];
  // One extra stage on cs_n so the word is fully shifted in
  assign frame_end   = cs_r[2] & ~cs_r[3];

  // MSB first
  assign cipo = tx_shift[word_bits-1];

  always_ff @(posedge CLK) begin
    if (reset) begin
      sck_r       <= '0;
      cs_r        <= '1;
      copi_r      <= '0;
      word_strobe <= 1'b0;
    end else begin
      sck_r       <= {sck_r[1:0], sck};
      cs_r        <= {cs_r[2:0], cs_n};
      copi_r      <= {copi_r[0], copi};
      word_strobe <= frame_end;
    end
  end

  always_ff @(posedge CLK) begin
    // Mode 0, sample on rising SCK
    if (sck_rise && in_frame) begin
      rx_shift <= {rx_shift[word_bits-2:0], copi_r[1]};
    end
    // Reply is loaded as the frame opens, then shifted on falling SCK
    if (frame_start) begin
      tx_shift <= reply_data;
    end else if (sck_fall && in_frame) begin
      tx_shift <= {tx_shift[word_bits-2:0], 1'b0};
    end
    if (frame_end) begin
      word_data <= rx_shift;
    end
  end

  // Frames are far longer than one cycle
  a_strobe_single : assert property (@(posedge CLK) disable iff (reset)
    word_strobe |=> !word_strobe);

endmodule

// File: stepper_ctrl.f
stepper_ctrl_pkg.sv
move_if.sv
spi_word_rx.sv
cmd_decoder.sv
dda_step_gen.sv
hbridge_phase.sv
quad_counter.sv
stepper_ctrl_top.sv
tb_clock_gen.sv
tb_stepper_ctrl.sv

// File: stepper_ctrl_pkg.sv
package stepper_ctrl_pkg;

  // Width of one SPI word
  localparam int word_bits = 64;

  // Message header codes
  localparam logic [7:0] cmd_move      = 8'h01;
  localparam logic [7:0] cmd_divisor   = 8'h03;
  localparam logic [7:0] cmd_step_mode = 8'h04;
  localparam logic [7:0] cmd_version   = 8'hfe;

  // Subtracted from the DDA accumulator on every step
  localparam logic signed [word_bits-1:0] dda_threshold = 64'sh7fffffffffffff9b;

  // Reported after a version header
  localparam logic [7:0] version_major = 8'd1;
  localparam logic [7:0] version_minor = 8'd2;
  localparam logic [7:0] version_patch = 8'd0;

  // 400 kHz ticks from the 16 MHz board clock
  localparam logic [23:0] default_divisor = 24'd40;

  // One SPI word, seen as a header or as a data word
  typedef union packed {
    struct packed {
      logic [7:0]           header;
      logic [word_bits-9:0] payload;
    } hdr;
    // Move parameters, signed
    logic signed [word_bits-1:0] data;
  } cmd_word_u;

endpackage

// File: stepper_ctrl_top.sv
`timescale 1ns/1ns

module stepper_ctrl_top #(
  parameter int MOVE_DEPTH = 4
) (
  input  logic CLK,
  input  logic reset,
  input  logic sck,
  input  logic cs_n,
  input  logic copi,
  input  logic enc_a,
  input  logic enc_b,
  output logic cipo,
  output logic step,
  output logic dir,
  output logic phase_a1,
  output logic phase_a2,
  output logic phase_b1,
  output logic phase_b2,
  output logic enc_fault
);
  import stepper_ctrl_pkg::*;

  logic                        word_strobe;
  logic [word_bits-1:0]        word_data;
  logic [word_bits-1:0]        reply_data;
  logic [23:0]                 clock_divisor;
  logic                        half_step;
  logic signed [word_bits-1:0] enc_count;

  // Queue head from decoder to step generator
  move_if mv ();

  spi_word_rx u_spi (
    .CLK         (CLK),
    .reset       (reset),
    .sck         (sck),
    .cs_n        (cs_n),
    .copi        (copi),
    .cipo        (cipo),
    .word_strobe (word_strobe),
    .word_data   (word_data),
    .reply_data  (reply_data)
  );

  cmd_decoder #(
    .MOVE_DEPTH (MOVE_DEPTH)
  ) u_dec (
    .CLK           (CLK),
    .reset         (reset),
    .word_strobe   (word_strobe),
    .word_data     (word_data),
    .enc_count     (enc_count),
    .reply_data    (reply_data),
    .clock_divisor (clock_divisor),
    .half_step     (half_step),
    .mv            (mv.producer)
  );

  dda_step_gen u_dda (
    .CLK           (CLK),
    .reset         (reset),
    .clock_divisor (clock_divisor),
    .mv            (mv.consumer),
    .step          (step),
    .dir           (dir)
  );

  hbridge_phase u_phase (
    .CLK       (CLK),
    .reset     (reset),
    .step      (step),
    .dir       (dir),
    .half_step (half_step),
    .phase_a1  (phase_a1),
    .phase_a2  (phase_a2),
    .phase_b1  (phase_b1),
    .phase_b2  (phase_b2)
  );

  quad_counter u_enc (
    .CLK   (CLK),
    .reset (reset),
    .enc_a (enc_a),
    .enc_b (enc_b),
    .count (enc_count),
    .fault (enc_fault)
  );

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
  output logic CLK,
  output logic reset
);

  // 10 ns period
  localparam int half_period = 5;
  localparam int reset_cycles = 3;

  initial begin
    CLK = 1'b0;
    forever #(half_period) CLK = ~CLK;
  end

  // Released just after an edge, away from the sampling point
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge CLK);
    #1;
    reset = 1'b0;
  end

endmodule

// File: tb_stepper_ctrl.sv
`timescale 1ns/1ns

module tb_stepper_ctrl;
  import stepper_ctrl_pkg::*;

  // Lead-in, 64 bits of two half periods, tail, strobe wait and gap
  localparam int frame_cycles = 1050;
  localparam int num_frames = 33;
  localparam int num_moves = 6;
  localparam logic [23:0] tb_divisor = 24'd8;
  // Slow ticks so later moves wait in the queue
  localparam logic [23:0] queue_divisor = 24'd600;

  logic CLK;
  logic reset;
  logic sck;
  logic cs_n;
  logic copi;
  logic enc_a;
  logic enc_b;
  logic cipo;
  logic step;
  logic dir;
  logic phase_a1;
  logic phase_a2;
  logic phase_b1;
  logic phase_b2;
  logic enc_fault;

  int checks = 0;
  int errors = 0;
  int step_count = 0;
  int phase_checks = 0;
  int exp_total = 0;
  int cycle_cnt = 0;
  int cycle_limit = 0;
  logic limit_set = 1'b0;
  logic [15:0] lfsr = 16'd46;
  // Expected dir for each step still to come
  logic exp_dirs[$];
  logic signed [63:0] ref_acc = '0;
  logic [2:0] exp_idx = 3'd0;
  logic half_mode = 1'b0;
  logic [1:0] enc_pos = 2'd0;
  int enc_fwd;
  int enc_back;
  logic mv_dir [num_moves];
  logic [63:0] mv_dur [num_moves];
  logic signed [63:0] mv_inc [num_moves];
  logic signed [63:0] mv_ii [num_moves];

  tb_clock_gen u_clk (
    .CLK   (CLK),
    .reset (reset)
  );

  stepper_ctrl_top #(
    .MOVE_DEPTH (4)
  ) u_dut (
    .CLK       (CLK),
    .reset     (reset),
    .sck       (sck),
    .cs_n      (cs_n),
    .copi      (copi),
    .enc_a     (enc_a),
    .enc_b     (enc_b),
    .cipo      (cipo),
    .step      (step),
    .dir       (dir),
    .phase_a1  (phase_a1),
    .phase_a2  (phase_a2),
    .phase_b1  (phase_b1),
    .phase_b2  (phase_b2),
    .enc_fault (enc_fault)
  );

  // 16-bit Galois LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [63:0] draw_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[62:0], lfsr[0]};
    end
    return v;
  endfunction

  // DDA rule per tick, accumulator carried in and out
  function automatic int ref_steps(input logic [63:0] dur, input logic signed [63:0] inc,
                                   input logic signed [63:0] ii,
                                   inout logic signed [63:0] acc);
    logic signed [63:0] cur;
    int n;
    cur = inc;
    n = 0;
    for (longint t = 0; t < dur; t++) begin
      if (t != 0) begin
        cur = cur + ii;
      end
      acc = acc + cur;
      if (acc > 0) begin
        n++;
        acc = acc - dda_threshold;
      end
    end
    return n;
  endfunction

  // Half-step sequence as {a1, a2, b1, b2}, state 0 is A1 and B1
  function automatic logic [3:0] phase_of(input logic [2:0] idx);
    case (idx)
      3'd0: return 4'b1010;
      3'd1: return 4'b0010;
      3'd2: return 4'b0110;
      3'd3: return 4'b0100;
      3'd4: return 4'b0101;
      3'd5: return 4'b0001;
      3'd6: return 4'b1001;
      default: return 4'b1000;
    endcase
  endfunction

  // A leads B going up
  function automatic logic [1:0] gray_of(input logic [1:0] pos);
    case (pos)
      2'd0: return 2'b00;
      2'd1: return 2'b10;
      2'd2: return 2'b11;
      default: return 2'b01;
    endcase
  endfunction

  task automatic wait_cycle();
    @(posedge CLK);
    #1;
  endtask

  task automatic expect_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    checks++;
    assert (got === exp) else begin
      $display("Fail %0t: %s is %0h, expected %0h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    $display("test %s: %s", name, (errors == err_before) ? "ok" : "mismatch");
  endtask

  // Mode 0 host, SCK half period of 8 clocks
  task automatic spi_frame(input logic [63:0] tx, output logic [63:0] rx);
    int waited;
    cs_n = 1'b0;
    for (int i = 63; i >= 0; i--) begin
      copi = tx[i];
      repeat (8) wait_cycle();
      sck = 1'b1;
      rx[i] = cipo;
      repeat (8) wait_cycle();
      sck = 1'b0;
    end
    repeat (8) wait_cycle();
    cs_n = 1'b1;
    waited = 0;
    while (u_dut.word_strobe !== 1'b1 && waited < 8) begin
      wait_cycle();
      waited++;
    end
    checks++;
    assert (waited < 8) else begin
      $display("At %0t the DUT gave no word strobe after the frame", $time);
      errors++;
    end
    repeat (3) wait_cycle();
  endtask

  task automatic enc_move(input int n, input logic fwd);
    for (int i = 0; i < n; i++) begin
      enc_pos = fwd ? enc_pos + 2'd1 : enc_pos - 2'd1;
      {enc_a, enc_b} = gray_of(enc_pos);
      repeat (6) wait_cycle();
    end
  endtask

  // Header with dir, then duration, increment, increment-of-increment
  task automatic send_move(input int k);
    logic [63:0] r;
    spi_frame({cmd_move, 55'd0, mv_dir[k]}, r);
    spi_frame(mv_dur[k], r);
    spi_frame(mv_inc[k], r);
    spi_frame(mv_ii[k], r);
  endtask

  task automatic expect_move(input int k);
    int n;
    n = ref_steps(mv_dur[k], mv_inc[k], mv_ii[k], ref_acc);
    exp_total += n;
    repeat (n) exp_dirs.push_back(mv_dir[k]);
  endtask

  // Queue drained and generator idle, then a quiet stretch
  task automatic wait_idle(input int limit);
    int n;
    n = 0;
    while ((u_dut.mv.avail || u_dut.u_dda.busy || u_dut.mv.pop) && n < limit) begin
      wait_cycle();
      n++;
    end
    checks++;
    assert (n < limit) else begin
      $display("At %0t the step generator did not go idle", $time);
      errors++;
    end
    repeat (4 * tb_divisor) wait_cycle();
  endtask

  // Step pulses, dir and phase outputs, sampled mid-cycle
  initial begin : monitor
    logic pend;
    logic want_dir;
    pend = 1'b0;
    forever begin
      @(negedge CLK);
      // Phase outputs one cycle after the pulse
      if (pend) begin
        phase_checks++;
        expect_eq({phase_a1, phase_a2, phase_b1, phase_b2}, phase_of(exp_idx), "phase");
        pend = 1'b0;
      end
      if (step === 1'b1) begin
        step_count++;
        checks++;
        assert (exp_dirs.size() != 0) else begin
          $display("At %0t a step pulse came with no step expected", $time);
          errors++;
        end
        if (exp_dirs.size() != 0) begin
          want_dir = exp_dirs.pop_front();
          expect_eq(dir, want_dir, "dir at step");
        end
        if (dir) begin
          exp_idx = exp_idx + (half_mode ? 3'd1 : 3'd2);
        end else begin
          exp_idx = exp_idx - (half_mode ? 3'd1 : 3'd2);
        end
        pend = 1'b1;
      end
    end
  end

  initial begin : watchdog
    wait (limit_set);
    while (cycle_cnt < cycle_limit) begin
      @(posedge CLK);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, the run did not finish", cycle_cnt);
    $display("tests failed");
    $finish;
  end

  initial begin : main
    logic [63:0] r;
    logic signed [63:0] net;
    longint move_cycles;
    int e0;
    sck = 1'b0;
    cs_n = 1'b1;
    copi = 1'b0;
    enc_a = 1'b0;
    enc_b = 1'b0;
    // All random values drawn up front so the limit is known
    enc_fwd = 20 + draw_bits(5);
    enc_back = 1 + draw_bits(4);
    move_cycles = 0;
    for (int k = 0; k < num_moves; k++) begin
      mv_dur[k] = 20 + draw_bits(4);
      mv_inc[k] = (draw_bits(4) + 2) << 58;
      mv_ii[k] = draw_bits(3) << 50;
      // Moves 1 to 3 run at the slower divisor
      if (k >= 1 && k <= 3) begin
        move_cycles += mv_dur[k] * queue_divisor;
      end else begin
        move_cycles += mv_dur[k] * tb_divisor;
      end
    end
    mv_dir[0] = draw_bits(1);
    mv_dir[1] = 1'b1;
    mv_dir[2] = 1'b0;
    mv_dir[3] = 1'b1;
    mv_dir[4] = 1'b1;
    mv_dir[5] = 1'b0;
    // Rising, falling and flat ramps for the queued moves
    mv_ii[1] = mv_ii[1] + (64'sd1 <<< 50);
    mv_ii[2] = -mv_ii[2] - (64'sd1 <<< 50);
    mv_ii[3] = '0;
    cycle_limit = num_frames * frame_cycles + (enc_fwd + enc_back + 2) * 6 + move_cycles + 2000;
    limit_set = 1'b1;
    wait (reset == 1'b0);
    wait_cycle();

    // Version reply in the next frame
    e0 = errors;
    spi_frame({cmd_version, 56'd0}, r);
    spi_frame(64'd0, r);
    expect_eq(r[23:0], {version_major, version_minor, version_patch}, "version reply");
    report_test("1 version", e0);

    // Net encoder count, then a fault
    e0 = errors;
    enc_move(enc_fwd, 1'b1);
    enc_move(enc_back, 1'b0);
    net = enc_fwd - enc_back;
    spi_frame(64'd0, r);
    spi_frame(64'd0, r);
    expect_eq(r, net, "encoder count reply");
    expect_eq(enc_fault, 1'b0, "enc_fault before double edge");
    // Both lines at once
    {enc_a, enc_b} = ~{enc_a, enc_b};
    enc_pos = enc_pos + 2'd2;
    repeat (6) wait_cycle();
    expect_eq(enc_fault, 1'b1, "enc_fault after double edge");
    report_test("2 encoder", e0);

    // Single move at divisor 8
    e0 = errors;
    spi_frame({cmd_divisor, 32'd0, tb_divisor}, r);
    expect_move(0);
    send_move(0);
    wait_idle(mv_dur[0] * tb_divisor + 200);
    expect_eq(step_count, exp_total, "step count, single move");
    report_test("3 single move", e0);

    // Three queued moves, accumulator carried over
    // First move outlasts the frames of the other two
    e0 = errors;
    spi_frame({cmd_divisor, 32'd0, queue_divisor}, r);
    for (int k = 1; k <= 3; k++) begin
      expect_move(k);
    end
    for (int k = 1; k <= 3; k++) begin
      send_move(k);
    end
    wait_idle((mv_dur[1] + mv_dur[2] + mv_dur[3]) * queue_divisor + 200);
    expect_eq(step_count, exp_total, "step count, queued moves");
    report_test("4 queued moves", e0);

    // Half step forward, then full step back
    e0 = errors;
    spi_frame({cmd_divisor, 32'd0, tb_divisor}, r);
    spi_frame({cmd_step_mode, 55'd0, 1'b1}, r);
    half_mode = 1'b1;
    expect_move(4);
    send_move(4);
    wait_idle(mv_dur[4] * tb_divisor + 200);
    spi_frame({cmd_step_mode, 55'd0, 1'b0}, r);
    half_mode = 1'b0;
    expect_move(5);
    send_move(5);
    wait_idle(mv_dur[5] * tb_divisor + 200);
    expect_eq(step_count, exp_total, "step count, step modes");
    report_test("5 phase table", e0);

    $display("checks %0d, errors %0d, steps %0d, phase checks %0d",
             checks, errors, step_count, phase_checks);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
